/* common/zap_defs.svh */
`ifndef ZAP_DEFS_SVH
`define ZAP_DEFS_SVH

// ----------------------------------------
// Bus widths.
// ----------------------------------------

`define ZAP_ADR_W               32      // Byte address.
`define ZAP_DAT_W               32      // One word.
`define ZAP_SEL_W               4       // One select per byte lane.

// ----------------------------------------
// Interrupt synchronizer.
// ----------------------------------------

// Two ranks are enough at the target clock rate.
`define ZAP_SYNC_STAGES         2

// ----------------------------------------
// Lane mode.
// ----------------------------------------

// 1 selects BE-32 byte lanes on the data side.
`define ZAP_BE_32_ENABLE        1

`endif

/* common/zap_pkg.sv */
`include "zap_defs.svh"

package zap_pkg;

        // ----------------------------------------
        // Core side.
        // ----------------------------------------

        // Instruction fetch request.
        typedef struct packed {
                logic                   stb;
                logic [`ZAP_ADR_W-1:0]  adr;
        } code_req_t;

        // Load/store request.
        typedef struct packed {
                logic                   stb;
                logic                   we;     // High for a store.
                logic [`ZAP_SEL_W-1:0]  sel;
                logic [`ZAP_DAT_W-1:0]  dat;
                logic [`ZAP_ADR_W-1:0]  adr;
        } data_req_t;

        // Returned to either core port.
        typedef struct packed {
                logic                   ack;
                logic [`ZAP_DAT_W-1:0]  dat;
        } port_rsp_t;

        // ----------------------------------------
        // Wishbone side.
        // ----------------------------------------

        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [`ZAP_SEL_W-1:0]  sel;
                logic [`ZAP_DAT_W-1:0]  dat;
                logic [`ZAP_ADR_W-1:0]  adr;
        } wb_req_t;

        typedef struct packed {
                logic                   ack;
                logic [`ZAP_DAT_W-1:0]  dat;
        } wb_rsp_t;

        // ----------------------------------------
        // Merger FSM.
        // ----------------------------------------

        typedef enum logic [1:0] {
                ST_IDLE = 2'd0,         // Bus free.
                ST_CODE = 2'd1,         // Fetch on the bus.
                ST_DATA = 2'd2          // Load/store on the bus.
        } merger_state_t;

endpackage

/* design/zap_irq_sync.sv */
`timescale 1ns/1ps

`include "zap_defs.svh"

module zap_irq_sync
(
        // Clock and reset.
        input   logic   i_clk,
        input   logic   i_reset,

        // Level triggered, from outside the clock domain.
        input   logic   i_irq,
        input   logic   i_fiq,

        // To the core.
        output  logic   o_irq,
        output  logic   o_fiq
);

// Both lines share one chain, bit 0 is IRQ and bit 1 is FIQ.
logic [`ZAP_SYNC_STAGES-1:0][1:0] sync_q;

// ----------------------------------------
// Flop ranks.
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if ( i_reset )
        begin
                sync_q <= '0;                   // Interrupts inactive.
        end
        else
        begin
                // Rank 0 may go metastable, later ranks settle it.
                sync_q <= {sync_q[`ZAP_SYNC_STAGES-2:0], {i_fiq, i_irq}};
        end
end

// Last rank feeds the core.
assign o_irq = sync_q[`ZAP_SYNC_STAGES-1][0];
assign o_fiq = sync_q[`ZAP_SYNC_STAGES-1][1];

endmodule

/* merger/zap_wb_merger.sv */
`timescale 1ns/1ps

`include "zap_defs.svh"

module zap_wb_merger #(
        parameter [0:0] BE_32_ENABLE = `ZAP_BE_32_ENABLE        // 1 swaps data lanes.
)
(
        // ----------------------------------------
        // Clock and reset.
        // ----------------------------------------

        input   logic                   i_clk,
        input   logic                   i_reset,

        // ----------------------------------------
        // Core ports.
        // ----------------------------------------

        input   zap_pkg::code_req_t     i_code_req,     // Fetch.
        input   zap_pkg::data_req_t     i_data_req,     // Load/store.
        output  zap_pkg::port_rsp_t     o_code_rsp,
        output  zap_pkg::port_rsp_t     o_data_rsp,

        // ----------------------------------------
        // Wishbone master.
        // ----------------------------------------

        output  zap_pkg::wb_req_t       o_wb,
        input   zap_pkg::wb_rsp_t       i_wb
);

// ----------------------------------------
// Lane swap helpers.
// ----------------------------------------

// Mirror the byte selects, lane 0 to lane 3 and so on.
function automatic logic [`ZAP_SEL_W-1:0] be_sel_32
(
        input logic [`ZAP_SEL_W-1:0] sel
);
        logic [`ZAP_SEL_W-1:0] rev;

        for ( int i = 0; i < `ZAP_SEL_W; i++ )
        begin
                rev[i] = sel[`ZAP_SEL_W-1-i];
        end

        return rev;
endfunction

// Reverse byte order of one word.
function automatic logic [`ZAP_DAT_W-1:0] be_dat_32
(
        input logic [`ZAP_DAT_W-1:0] dat
);
        logic [`ZAP_DAT_W-1:0] rev;

        for ( int i = 0; i < `ZAP_SEL_W; i++ )
        begin
                rev[8*i +: 8] = dat[8*(`ZAP_SEL_W-1-i) +: 8];
        end

        return rev;
endfunction

zap_pkg::merger_state_t state_q;
zap_pkg::merger_state_t state_nxt;

logic                   last_data_q;            // Data port served last.
logic                   grant_code;
logic                   grant_data;
logic                   bus_done;               // Ack of the open transfer.
logic [`ZAP_SEL_W-1:0]  data_sel;               // Sel as it goes on the bus.
logic [`ZAP_DAT_W-1:0]  data_rd_dat;            // Read word as the core sees it.

// Registered bus request.
logic                   wb_cyc_q;
logic                   wb_we_q;
logic [`ZAP_SEL_W-1:0]  wb_sel_q;
logic [`ZAP_DAT_W-1:0]  wb_dat_q;
logic [`ZAP_ADR_W-1:0]  wb_adr_q;

assign data_sel    = BE_32_ENABLE ? be_sel_32(i_data_req.sel) : i_data_req.sel;
assign data_rd_dat = BE_32_ENABLE ? be_dat_32(i_wb.dat) : i_wb.dat;
assign bus_done    = (state_q != zap_pkg::ST_IDLE) && i_wb.ack;

// ----------------------------------------
// Arbitration.
// ----------------------------------------

always_comb
begin
        grant_code = 1'd0;
        grant_data = 1'd0;

        // Only an idle bus takes a new request.
        if ( state_q == zap_pkg::ST_IDLE )
        begin
                if ( i_code_req.stb && i_data_req.stb )
                begin
                        // Tie goes to the port that waited last time.
                        grant_code = last_data_q;
                        grant_data = !last_data_q;
                end
                else
                begin
                        grant_code = i_code_req.stb;
                        grant_data = i_data_req.stb;
                end
        end
end

// ----------------------------------------
// Next state.
// ----------------------------------------

always_comb
begin
        state_nxt = state_q;

        case ( state_q )
        zap_pkg::ST_IDLE:
        begin
                if ( grant_data )
                        state_nxt = zap_pkg::ST_DATA;
                else if ( grant_code )
                        state_nxt = zap_pkg::ST_CODE;
        end

        zap_pkg::ST_CODE, zap_pkg::ST_DATA:
        begin
                if ( i_wb.ack )
                        state_nxt = zap_pkg::ST_IDLE;   // Bus free next cycle.
        end

        default:
        begin
                state_nxt = zap_pkg::ST_IDLE;
        end
        endcase
end

// ----------------------------------------
// Control flops.
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if ( i_reset )
        begin
                state_q     <= zap_pkg::ST_IDLE;
                last_data_q <= 1'd0;            // Code counts as served last.
                wb_cyc_q    <= 1'd0;
        end
        else
        begin
                state_q <= state_nxt;

                if ( grant_data )
                begin
                        last_data_q <= 1'd1;
                        wb_cyc_q    <= 1'd1;
                end
                else if ( grant_code )
                begin
                        last_data_q <= 1'd0;
                        wb_cyc_q    <= 1'd1;
                end
                else if ( bus_done )
                begin
                        wb_cyc_q    <= 1'd0;    // Drop cyc and stb after ack.
                end
        end
end

// ----------------------------------------
// Request payload.
// ----------------------------------------

// Loaded on grant, held until the next grant.
always_ff @(posedge i_clk)
begin
        if ( grant_data )
        begin
                wb_we_q  <= i_data_req.we;
                wb_sel_q <= data_sel;
                wb_dat_q <= i_data_req.dat;     // Write data is never swapped.
                wb_adr_q <= i_data_req.adr;
        end
        else if ( grant_code )
        begin
                wb_we_q  <= 1'd0;
                wb_sel_q <= '1;                 // Whole word.
                wb_dat_q <= '0;
                wb_adr_q <= i_code_req.adr;
        end
end

always_comb
begin
        o_wb.cyc = wb_cyc_q;
        o_wb.stb = wb_cyc_q;                    // Single classic cycles only.
        o_wb.we  = wb_we_q;
        o_wb.sel = wb_sel_q;
        o_wb.dat = wb_dat_q;
        o_wb.adr = wb_adr_q;
end

// ----------------------------------------
// Port responses.
// ----------------------------------------

always_comb
begin
        o_code_rsp = '0;
        o_data_rsp = '0;

        // Ack and read data go to the granted port only.
        if ( state_q == zap_pkg::ST_CODE )
        begin
                o_code_rsp.ack = i_wb.ack;
                o_code_rsp.dat = i_wb.dat;      // Fetch is never swapped.
        end

        if ( state_q == zap_pkg::ST_DATA )
        begin
                o_data_rsp.ack = i_wb.ack;
                o_data_rsp.dat = data_rd_dat;
        end
end

endmodule

/* design/zap_bus_unit.sv */
`timescale 1ns/1ps

`include "zap_defs.svh"

module zap_bus_unit #(
        // ----------------------------------------
        // Lane mode of the data port.
        // ----------------------------------------

        parameter [0:0] BE_32_ENABLE = `ZAP_BE_32_ENABLE
)
(
        // ----------------------------------------
        // Clock and reset.
        // ----------------------------------------

        input   logic                   i_clk,
        input   logic                   i_reset,

        // ----------------------------------------
        // Interrupts.
        // ----------------------------------------

        // Active high, level triggered.
        input   logic                   i_irq,
        input   logic                   i_fiq,

        // Synchronized copies for the core.
        output  logic                   o_irq,
        output  logic                   o_fiq,

        // ----------------------------------------
        // Core fetch and data ports.
        // ----------------------------------------

        input   zap_pkg::code_req_t     i_code_req,
        output  zap_pkg::port_rsp_t     o_code_rsp,

        input   zap_pkg::data_req_t     i_data_req,
        output  zap_pkg::port_rsp_t     o_data_rsp,

        // ----------------------------------------
        // Wishbone master.
        // ----------------------------------------

        output  zap_pkg::wb_req_t       o_wb,
        input   zap_pkg::wb_rsp_t       i_wb
);

// Interrupt lines into the clock domain.
zap_irq_sync u_sync
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq)
);

// Both core ports onto the one bus.
zap_wb_merger #(
        .BE_32_ENABLE   (BE_32_ENABLE)
) u_zap_wb_merger
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),

        .i_code_req     (i_code_req),
        .i_data_req     (i_data_req),
        .o_code_rsp     (o_code_rsp),
        .o_data_rsp     (o_data_rsp),

        .o_wb           (o_wb),
        .i_wb           (i_wb)
);

endmodule

/* dv/zap_tb_clock.sv */
`timescale 1ns/1ps

module zap_tb_clock
(
        output  logic   o_clk,
        output  logic   o_reset
);

localparam int HALF_PERIOD = 20;                // 40 ns clock.

initial
begin
        o_clk   = 1'b0;
        o_reset = 1'b1;
        repeat (2) @(posedge o_clk);            // Reset seen at two edges.
        #1;
        o_reset = 1'b0;
end

always #HALF_PERIOD o_clk = ~o_clk;

endmodule

/* dv/zap_tb_checker.sv */
`timescale 1ns/1ps

`include "zap_defs.svh"

module zap_tb_checker
(
        input   logic                   i_clk,
        input   logic                   i_reset,
        input   logic                   i_irq,
        input   logic                   i_fiq,
        input   logic                   i_dut_irq,
        input   logic                   i_dut_fiq,
        input   zap_pkg::code_req_t     i_code_req,
        input   zap_pkg::data_req_t     i_data_req,
        input   zap_pkg::port_rsp_t     i_code_rsp,
        input   zap_pkg::port_rsp_t     i_data_rsp,
        input   zap_pkg::wb_req_t       i_wb_req,
        input   zap_pkg::wb_rsp_t       i_wb_rsp,
        output  int                     o_value_errors,
        output  int                     o_protocol_errors,
        output  int                     o_transfers,
        output  int                     o_ties
);

zap_pkg::merger_state_t exp_state;              // Expected merger state.
zap_pkg::wb_req_t       exp_req;                // Bus request latched at grant.
logic                   last_data;
logic                   irq_d1, irq_d2, fiq_d1, fiq_d2;
logic [`ZAP_DAT_W-1:0]  ref_mem [0:63];

// ----------------------------------------
// Reference functions.
// ----------------------------------------

function automatic logic [3:0] lane_swap_sel(input logic [3:0] sel);
        return {sel[0], sel[1], sel[2], sel[3]};
endfunction

function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// A tie goes to the port that did not have the bus last.
function automatic zap_pkg::merger_state_t tie_winner(input logic last_was_data);
        return last_was_data ? zap_pkg::ST_CODE : zap_pkg::ST_DATA;
endfunction

function automatic logic [31:0] fill_word(input int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ idx;
endfunction

task automatic check_field(input string name, input logic [31:0] exp,
                           input logic [31:0] act, input bit ctrl);
        if (act !== exp)
        begin
                $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
                if (ctrl)
                        o_protocol_errors++;
                else
                        o_value_errors++;
        end
endtask

// ----------------------------------------
// Per-cycle comparison.
// ----------------------------------------

task automatic compare_outputs();
        logic           busy;
        logic [31:0]    word;

        busy = (exp_state != zap_pkg::ST_IDLE);
        word = ref_mem[exp_req.adr[7:2]];
        check_field("o_wb.cyc", busy, i_wb_req.cyc, 1'b1);
        check_field("o_wb.stb", busy, i_wb_req.stb, 1'b1);
        if (busy)
        begin
                // Held unchanged until ack.
                check_field("o_wb.we", exp_req.we, i_wb_req.we, 1'b0);
                check_field("o_wb.sel", exp_req.sel, i_wb_req.sel, 1'b0);
                check_field("o_wb.dat", exp_req.dat, i_wb_req.dat, 1'b0);
                check_field("o_wb.adr", exp_req.adr, i_wb_req.adr, 1'b0);
        end
        check_field("o_code_rsp.ack", (exp_state == zap_pkg::ST_CODE) && i_wb_rsp.ack,
                    i_code_rsp.ack, 1'b1);
        check_field("o_data_rsp.ack", (exp_state == zap_pkg::ST_DATA) && i_wb_rsp.ack,
                    i_data_rsp.ack, 1'b1);
        if (exp_state != zap_pkg::ST_CODE)
                check_field("o_code_rsp.dat", 32'h0, i_code_rsp.dat, 1'b0);
        else if (i_wb_rsp.ack)
                check_field("o_code_rsp.dat", word, i_code_rsp.dat, 1'b0);
        if (exp_state != zap_pkg::ST_DATA)
                check_field("o_data_rsp.dat", 32'h0, i_data_rsp.dat, 1'b0);
        else if (i_wb_rsp.ack && !exp_req.we)
                check_field("o_data_rsp.dat", byte_reverse(word), i_data_rsp.dat, 1'b0);
        check_field("o_irq", irq_d2, i_dut_irq, 1'b1);
        check_field("o_fiq", fiq_d2, i_dut_fiq, 1'b1);
endtask

task automatic advance_model();
        if (exp_state == zap_pkg::ST_IDLE)
        begin
                if (i_code_req.stb && i_data_req.stb)
                begin
                        exp_state = tie_winner(last_data);
                        o_ties++;
                end
                else if (i_data_req.stb)
                        exp_state = zap_pkg::ST_DATA;
                else if (i_code_req.stb)
                        exp_state = zap_pkg::ST_CODE;

                if (exp_state == zap_pkg::ST_DATA)
                begin
                        exp_req = {1'b1, 1'b1, i_data_req.we, lane_swap_sel(i_data_req.sel),
                                   i_data_req.dat, i_data_req.adr};
                        last_data = 1'b1;
                end
                else if (exp_state == zap_pkg::ST_CODE)
                begin
                        exp_req = {1'b1, 1'b1, 1'b0, 4'hf, 32'h0, i_code_req.adr};
                        last_data = 1'b0;
                end
        end
        else if (i_wb_rsp.ack)
        begin
                if (exp_req.we)
                begin
                        for (int i = 0; i < 4; i++)
                        begin
                                if (exp_req.sel[i])     // Bus lane i.
                                        ref_mem[exp_req.adr[7:2]][8*i +: 8] = exp_req.dat[8*i +: 8];
                        end
                end
                exp_state = zap_pkg::ST_IDLE;
                o_transfers++;
        end
endtask

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                exp_state         = zap_pkg::ST_IDLE;
                exp_req           = '0;
                last_data         = 1'b0;       // Code counts as served last.
                {irq_d1, irq_d2, fiq_d1, fiq_d2} = 4'h0;
                o_value_errors    = 0;
                o_protocol_errors = 0;
                o_transfers       = 0;
                o_ties            = 0;
                for (int i = 0; i < 64; i++)
                        ref_mem[i] = fill_word(i);
        end
        else
        begin
                compare_outputs();
                irq_d2 = irq_d1;                // Two-cycle history.
                irq_d1 = i_irq;
                fiq_d2 = fiq_d1;
                fiq_d1 = i_fiq;
                advance_model();
        end
end

endmodule

/* dv/zap_tb.sv */
`timescale 1ns/1ps

`include "zap_defs.svh"

module zap_tb;

localparam int N_TRANSFERS = 200;
localparam int CYCLE_LIMIT = N_TRANSFERS * 8 + 100;

logic                   clk, reset, irq, fiq, dut_irq, dut_fiq;
zap_pkg::code_req_t     code_req;
zap_pkg::data_req_t     data_req;
zap_pkg::port_rsp_t     code_rsp, data_rsp;
zap_pkg::wb_req_t       wb_req;
zap_pkg::wb_rsp_t       wb_rsp;
logic [31:0]            slave_mem [0:63];
logic                   slave_busy;
int                     wait_left, cycles, other_errors, total;
int                     value_errors, protocol_errors, transfers, ties;

zap_tb_clock u_clock (.o_clk(clk), .o_reset(reset));

zap_bus_unit #(.BE_32_ENABLE(1'b1)) dut
(
        .i_clk(clk), .i_reset(reset), .i_irq(irq), .i_fiq(fiq), .o_irq(dut_irq),
        .o_fiq(dut_fiq), .i_code_req(code_req), .o_code_rsp(code_rsp),
        .i_data_req(data_req), .o_data_rsp(data_rsp), .o_wb(wb_req), .i_wb(wb_rsp)
);

zap_tb_checker u_checker
(
        .i_clk(clk), .i_reset(reset), .i_irq(irq), .i_fiq(fiq), .i_dut_irq(dut_irq),
        .i_dut_fiq(dut_fiq), .i_code_req(code_req), .i_data_req(data_req),
        .i_code_rsp(code_rsp), .i_data_rsp(data_rsp), .i_wb_req(wb_req), .i_wb_rsp(wb_rsp),
        .o_value_errors(value_errors), .o_protocol_errors(protocol_errors),
        .o_transfers(transfers), .o_ties(ties)
);

// ----------------------------------------
// Core port drivers.
// ----------------------------------------

task automatic fetch_word();
        code_req.stb = 1'b1;
        code_req.adr = $urandom() & 32'hffff_fffc;
        do
                @(posedge clk);
        while (!code_rsp.ack);
        #1;
        code_req.stb = 1'b0;                    // Next request may follow at once.
endtask

task automatic access_data();
        logic [31:0] rnd;

        rnd          = $urandom();
        data_req.stb = 1'b1;
        data_req.we  = rnd[0];
        data_req.sel = rnd[7:4];
        data_req.dat = $urandom();
        data_req.adr = $urandom() & 32'hffff_fffc;
        do
                @(posedge clk);
        while (!data_rsp.ack);
        #1;
        data_req.stb = 1'b0;
endtask

initial
begin
        void'($urandom(32'heef0));
        code_req = '0;
        data_req = '0;
        @(negedge reset);
        fork                                    // One tie straight after reset.
                fetch_word();
                access_data();
        join
        repeat (40) fetch_word();               // Each port alone.
        repeat (40) access_data();
        fork                                    // Both ports together.
                repeat (59) fetch_word();
                repeat (59) access_data();
        join
        repeat (2) @(posedge clk);
        #1;
        other_errors = 0;
        if (transfers != N_TRANSFERS)
        begin
                $display("Transfer count wrong: %0d of %0d completed", transfers, N_TRANSFERS);
                other_errors++;
        end
        if (ties == 0)
        begin
                $display("No arbitration tie was seen during the run");
                other_errors++;
        end
        total = value_errors + protocol_errors + other_errors;
        $display("Counts: value errors %0d, protocol errors %0d, other errors %0d",
                 value_errors, protocol_errors, other_errors);
        if (total == 0)
                $display("No errors");
        else
                $display("Errors found");
        $finish;
end

// Wishbone slave of 64 words with 0 to 3 wait cycles.
initial
begin
        wb_rsp     = '0;
        slave_busy = 1'b0;
        wait_left  = 0;
        for (int i = 0; i < 64; i++)
                slave_mem[i] = (32'h9e37_79b9 * (i + 1)) ^ i;
        forever
        begin
                @(posedge clk);
                #1;
                if (reset || wb_rsp.ack)
                begin
                        wb_rsp     = '0;        // Master drops cyc after ack.
                        slave_busy = 1'b0;
                end
                else if (wb_req.cyc && wb_req.stb)
                begin
                        if (!slave_busy)
                        begin
                                slave_busy = 1'b1;
                                wait_left  = $urandom_range(3, 0);
                        end
                        if (wait_left == 0)
                        begin
                                for (int i = 0; i < 4; i++)
                                begin
                                        if (wb_req.we && wb_req.sel[i])
                                                slave_mem[wb_req.adr[7:2]][8*i +: 8] =
                                                        wb_req.dat[8*i +: 8];
                                end
                                wb_rsp.ack = 1'b1;
                                wb_rsp.dat = wb_req.we ? 32'h0 : slave_mem[wb_req.adr[7:2]];
                        end
                        else
                                wait_left--;
                end
        end
end

initial
begin
        irq = 1'b0;
        fiq = 1'b0;
        forever
        begin
                @(posedge clk);
                #1;
                if ($urandom_range(7, 0) == 0)
                        irq = ~irq;
                if ($urandom_range(7, 0) == 0)
                        fiq = ~fiq;
        end
end

always @(posedge clk)
begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
                $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Errors found");
                $finish;
        end
end

initial cycles = 0;

endmodule

/* list.f */
+incdir+common
common/zap_pkg.sv
design/zap_irq_sync.sv
merger/zap_wb_merger.sv
design/zap_bus_unit.sv
dv/zap_tb_clock.sv
dv/zap_tb_checker.sv
dv/zap_tb.sv

/* Bender.yml */
package:
  name: zap_bus_unit

export_include_dirs:
  - common

sources:
  - common/zap_pkg.sv
  - design/zap_irq_sync.sv
  - merger/zap_wb_merger.sv
  - design/zap_bus_unit.sv
  - target: simulation
    files:
      - dv/zap_tb_clock.sv
      - dv/zap_tb_checker.sv
      - dv/zap_tb.sv
